/* include/soc_consts.svh */
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// RAM word address width for 256 words.
`define RAM_BITS 8

// Byte lanes per RAM word.
`define RAM_LANES 4

// Region selector is addr[31:SELECT_LSB].
`define SELECT_LSB 27

`define SEL_RAM 5'h02
`define SEL_TIMER 5'h1C
`define SEL_PORTS 5'h1F

// Clock cycles per timer tick.
`define TIMER_PRESCALE 4

`define TIMER_BITS 16

`endif

/* design/soc_pkg.sv */
package soc_pkg;

    // Class of an accepted bus access.
    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_RAM,
        REGION_TIMER,
        REGION_PORTS
    } region_e;

    typedef enum logic [1:0] {
        TIMER_IDLE,
        TIMER_COUNTING,
        TIMER_EXPIRED
    } timer_state_e;

endpackage

/* design/bus_decoder.sv */
`include "soc_consts.svh"

module bus_decoder (
    input  logic                   mem_valid,
    input  logic                   nreset,
    input  logic [31:0]            addr,
    input  logic [31:0]            wdata,
    input  logic [3:0]             wstrb,
    input  logic                   read,
    input  logic                   write,
    output soc_pkg::region_e       acc_region,
    output logic                   acc_read,
    output logic                   acc_write,
    output logic [`RAM_BITS-1:0]   ram_addr,
    output logic [`RAM_LANES-1:0]  lane_we,
    output logic [31:0]            acc_wdata,
    output logic                   acc_wstrb0,
    output logic                   timer_load
);
    import soc_pkg::*;

    region_e region;
    logic    request;

    assign request = read | write;

    always_comb begin
        case (addr[31:`SELECT_LSB])
            `SEL_RAM:   region = REGION_RAM;
            `SEL_TIMER: region = REGION_TIMER;
            `SEL_PORTS: region = REGION_PORTS;
            default:    region = REGION_NONE;
        endcase
        // Idle cycles carry no region.
        if (!request)
            region = REGION_NONE;
    end

    always_ff @(posedge mem_valid) begin
        if (!nreset) begin
            acc_region <= REGION_NONE;
            acc_read   <= 1'b0;
            acc_write  <= 1'b0;
            lane_we    <= '0;
            timer_load <= 1'b0;
        end else begin
            acc_region <= region;
            acc_read   <= read;
            acc_write  <= write;
            lane_we    <= (write && region == REGION_RAM) ? wstrb : '0;
            timer_load <= write && region == REGION_TIMER;
        end
    end

    // Address and data held until the next request.
    always_ff @(posedge mem_valid) begin
        if (request) begin
            ram_addr   <= addr[`RAM_BITS+1:2];
            acc_wdata  <= wdata;
            acc_wstrb0 <= wstrb[0];
        end
    end

    a_single_strobe: assert property (
        @(posedge mem_valid) disable iff (!nreset) !(read && write)
    ) else $error("read and write high together");

endmodule

/* design/ram_lane.sv */
`include "soc_consts.svh"

module ram_lane (
    input  logic                 mem_valid,
    input  logic [`RAM_BITS-1:0] addr,
    input  logic                 we,
    input  logic [7:0]           wdata,
    output logic [7:0]           rdata
);
    logic [7:0] mem [0:(1<<`RAM_BITS)-1];

    always_ff @(posedge mem_valid) begin
        if (we)
            mem[addr] <= wdata;
    end

    // Write-first read port.
    always_ff @(posedge mem_valid) begin
        if (we)
            rdata <= wdata;
        else
            rdata <= mem[addr];
    end

endmodule

/* design/interval_timer.sv */
`include "soc_consts.svh"

module interval_timer (
    input  logic                   mem_valid,
    input  logic                   nreset,
    input  logic                   load,
    input  logic [`TIMER_BITS-1:0] value,
    input  logic                   irq_clear,
    output logic [`TIMER_BITS-1:0] count,
    output logic                   irq
);
    import soc_pkg::*;

    localparam int PRE_BITS = $clog2(`TIMER_PRESCALE);

    timer_state_e        state;
    logic [PRE_BITS-1:0] prescale;
    logic                tick;

    assign tick = prescale == PRE_BITS'(`TIMER_PRESCALE - 1);

    always_ff @(posedge mem_valid) begin
        if (!nreset) begin
            state    <= TIMER_IDLE;
            count    <= '0;
            prescale <= '0;
            irq      <= 1'b0;
        end else if (load) begin
            // A zero load stops the timer.
            state    <= (value == '0) ? TIMER_IDLE : TIMER_COUNTING;
            count    <= value;
            prescale <= '0;
            irq      <= 1'b0;
        end else if (irq_clear) begin
            state <= TIMER_IDLE;
            irq   <= 1'b0;
        end else if (state == TIMER_COUNTING) begin
            prescale <= tick ? '0 : prescale + 1'b1;
            if (tick) begin
                count <= count - 1'b1;
                if (count == `TIMER_BITS'(1)) begin
                    state <= TIMER_EXPIRED;
                    irq   <= 1'b1;
                end
            end
        end
    end

    a_irq_expired: assert property (
        @(posedge mem_valid) disable iff (!nreset) irq |-> state == TIMER_EXPIRED
    ) else $error("irq high outside expired state");

endmodule

/* design/io_ports.sv */
`include "soc_consts.svh"

module io_ports (
    input  logic             mem_valid,
    input  logic             nreset,
    input  soc_pkg::region_e region,
    input  logic             write,
    input  logic             wstrb0,
    input  logic [2:0]       wdata_low,
    input  logic             con_button,
    input  logic             psh_button,
    input  logic             tra,
    input  logic             trb,
    input  logic             bak_button,
    input  logic             scl_in,
    input  logic             sda_in,
    output logic             led,
    output logic             scl,
    output logic             sda,
    output logic [6:0]       port_rdata
);
    import soc_pkg::*;

    // Serial bus lines idle high.
    always_ff @(posedge mem_valid) begin
        if (!nreset)
            {led, scl, sda} <= 3'b111;
        else if (region == REGION_PORTS && write && wstrb0)
            {led, scl, sda} <= wdata_low;
    end

    always_ff @(posedge mem_valid) begin
        if (region == REGION_PORTS)
            port_rdata <= {con_button, psh_button, tra, trb, bak_button, scl_in, sda_in};
    end

endmodule

/* design/read_mux.sv */
`include "soc_consts.svh"

module read_mux (
    input  logic                      mem_valid,
    input  logic                      nreset,
    input  soc_pkg::region_e          acc_region,
    input  logic                      acc_read,
    input  logic                      acc_write,
    input  logic [`RAM_LANES*8-1:0]   lane_rdata,
    input  logic [`TIMER_BITS-1:0]    count,
    input  logic [6:0]                port_rdata,
    output logic [31:0]               rdata,
    output logic                      ready
);
    import soc_pkg::*;

    region_e                resp_region;
    logic [`TIMER_BITS-1:0] timer_count;

    always_ff @(posedge mem_valid) begin
        if (!nreset) begin
            resp_region <= REGION_NONE;
            ready       <= 1'b0;
        end else begin
            resp_region <= acc_region;
            // Unmapped accesses are never acknowledged.
            ready       <= acc_region != REGION_NONE;
        end
    end

    always_ff @(posedge mem_valid) begin
        if (acc_region == REGION_TIMER)
            timer_count <= count;
    end

    always_comb begin
        case (resp_region)
            REGION_RAM:   rdata = lane_rdata;
            REGION_TIMER: rdata = {{(32-`TIMER_BITS){1'b0}}, timer_count};
            REGION_PORTS: rdata = {25'b0, port_rdata};
            default:      rdata = '0;
        endcase
    end

    // Back-to-back acknowledges need back-to-back requests.
    a_ready_pairs: assert property (
        @(posedge mem_valid) disable iff (!nreset)
        ready && $past(ready) |-> $past(acc_read || acc_write)
                                  && $past(acc_read || acc_write, 2)
    ) else $error("ready held without consecutive requests");

endmodule

/* design/soc_memory.sv */
`include "soc_consts.svh"

module soc_memory (
    input  logic        mem_valid,
    input  logic        nreset,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        read,
    input  logic        write,
    output logic [31:0] rdata,
    output logic        ready,
    input  logic        irq_clear,
    output logic        irq,
    input  logic        con_button,
    input  logic        psh_button,
    input  logic        tra,
    input  logic        trb,
    input  logic        bak_button,
    input  logic        scl_in,
    input  logic        sda_in,
    output logic        led,
    output logic        scl,
    output logic        sda
);
    import soc_pkg::*;

    region_e                  acc_region;
    logic                     acc_read;
    logic                     acc_write;
    logic [`RAM_BITS-1:0]     ram_addr;
    logic [`RAM_LANES-1:0]    lane_we;
    logic [31:0]              acc_wdata;
    logic                     acc_wstrb0;
    logic                     timer_load;
    logic [`RAM_LANES*8-1:0]  lane_rdata;
    logic [`TIMER_BITS-1:0]   count;
    logic [6:0]               port_rdata;

    bus_decoder decoder_i (
        .mem_valid(mem_valid), .nreset(nreset), .addr(addr), .wdata(wdata),
        .wstrb(wstrb), .read(read), .write(write), .acc_region(acc_region),
        .acc_read(acc_read), .acc_write(acc_write), .ram_addr(ram_addr),
        .lane_we(lane_we), .acc_wdata(acc_wdata), .acc_wstrb0(acc_wstrb0),
        .timer_load(timer_load)
    );

    // Lane 0 holds the low byte.
    for (genvar i = 0; i < `RAM_LANES; i++) begin : lane_gen
        ram_lane lane_i (
            .mem_valid(mem_valid), .addr(ram_addr), .we(lane_we[i]),
            .wdata(acc_wdata[i*8 +: 8]), .rdata(lane_rdata[i*8 +: 8])
        );
    end

    interval_timer timer_i (
        .mem_valid(mem_valid), .nreset(nreset), .load(timer_load),
        .value(acc_wdata[`TIMER_BITS-1:0]), .irq_clear(irq_clear),
        .count(count), .irq(irq)
    );

    io_ports ports_i (
        .mem_valid(mem_valid), .nreset(nreset), .region(acc_region),
        .write(acc_write), .wstrb0(acc_wstrb0), .wdata_low(acc_wdata[2:0]),
        .con_button(con_button), .psh_button(psh_button), .tra(tra), .trb(trb),
        .bak_button(bak_button), .scl_in(scl_in), .sda_in(sda_in),
        .led(led), .scl(scl), .sda(sda), .port_rdata(port_rdata)
    );

    read_mux mux_i (
        .mem_valid(mem_valid), .nreset(nreset), .acc_region(acc_region),
        .acc_read(acc_read), .acc_write(acc_write), .lane_rdata(lane_rdata),
        .count(count), .port_rdata(port_rdata), .rdata(rdata), .ready(ready)
    );

endmodule

/* test/soc_memory_tb.sv */
`include "soc_consts.svh"

module soc_memory_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WORD_TESTS = 12;
    localparam int STROBE_TESTS = 8;
    localparam int ACCESS_WAIT = 6;
    localparam int TIMER_MAX = 10;
    localparam int ACCESSES = 2 * WORD_TESTS + 3 * STROBE_TESTS + 16;
    // Twice the worst case of all tests.
    localparam int CYCLE_LIMIT =
        2 * (5 + ACCESSES * ACCESS_WAIT + 4 * (TIMER_MAX + 1) * `TIMER_PRESCALE);

    logic        mem_valid;
    logic        nreset;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        read;
    logic        write;
    logic [31:0] rdata;
    logic        ready;
    logic        irq_clear;
    logic        irq;
    logic        con_button;
    logic        psh_button;
    logic        tra;
    logic        trb;
    logic        bak_button;
    logic        scl_in;
    logic        sda_in;
    logic        led;
    logic        scl;
    logic        sda;

    logic [15:0] lfsr_state;
    logic [31:0] model [0:(1<<`RAM_BITS)-1];
    int          errors;
    int          checks;
    int          cycles;

    soc_memory soc_memory_i (
        .mem_valid(mem_valid), .nreset(nreset), .addr(addr), .wdata(wdata),
        .wstrb(wstrb), .read(read), .write(write), .rdata(rdata), .ready(ready),
        .irq_clear(irq_clear), .irq(irq), .con_button(con_button),
        .psh_button(psh_button), .tra(tra), .trb(trb), .bak_button(bak_button),
        .scl_in(scl_in), .sda_in(sda_in), .led(led), .scl(scl), .sda(sda)
    );

    initial mem_valid = 1'b0;

    always #20 mem_valid = ~mem_valid;

    always @(posedge mem_valid) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken.
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hB400 : lfsr_state >> 1;
        end
        return r;
    endfunction

    function automatic logic [31:0] region_base(input logic [4:0] sel);
        return {27'b0, sel} << `SELECT_LSB;
    endfunction

    function automatic logic [31:0] ram_address(input logic [`RAM_BITS-1:0] word);
        return region_base(`SEL_RAM) | (32'(word) << 2);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // Starts on a falling edge and returns on the one where ready is seen.
    task automatic bus_access(input logic is_write, input logic [31:0] a,
                              input logic [31:0] d, input logic [3:0] s,
                              output logic [31:0] data);
        int waited;
        addr = a;
        wdata = d;
        wstrb = s;
        write = is_write;
        read = !is_write;
        @(negedge mem_valid);
        read = 1'b0;
        write = 1'b0;
        waited = 0;
        do begin
            @(negedge mem_valid);
            waited++;
        end while (!ready && waited < ACCESS_WAIT);
        data = rdata;
        if (!ready) begin
            errors++;
            $display("no ready within %0d cycles for access to %h", ACCESS_WAIT, a);
        end else begin
            check_value("ready latency", 32'(waited), 32'd1);
        end
    endtask

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
        logic [31:0] ignored;
        bus_access(1'b1, a, d, s, ignored);
    endtask

    task automatic bus_read(input logic [31:0] a, output logic [31:0] data);
        bus_access(1'b0, a, 32'd0, 4'd0, data);
    endtask

    task automatic check_reset_state;
        check_value("led", 32'(led), 32'd1);
        check_value("scl", 32'(scl), 32'd1);
        check_value("sda", 32'(sda), 32'd1);
        check_value("ready", 32'(ready), 32'd0);
        check_value("irq", 32'(irq), 32'd0);
    endtask

    task automatic ram_words;
        logic [`RAM_BITS-1:0] word;
        logic [31:0]          got;
        for (int i = 0; i < WORD_TESTS; i++) begin
            word = `RAM_BITS'(random_bits(`RAM_BITS));
            model[word] = random_bits(32);
            bus_write(ram_address(word), model[word], 4'hF);
            bus_read(ram_address(word), got);
            check_value("rdata", got, model[word]);
        end
        // Write and read the same word on consecutive cycles.
        word = `RAM_BITS'(random_bits(`RAM_BITS));
        model[word] = random_bits(32);
        addr = ram_address(word);
        wdata = model[word];
        wstrb = 4'hF;
        write = 1'b1;
        @(negedge mem_valid);
        write = 1'b0;
        read = 1'b1;
        wstrb = 4'h0;
        @(negedge mem_valid);
        read = 1'b0;
        check_value("ready", 32'(ready), 32'd1);
        @(negedge mem_valid);
        check_value("ready", 32'(ready), 32'd1);
        check_value("rdata", rdata, model[word]);
    endtask

    task automatic byte_strobes;
        logic [`RAM_BITS-1:0] word;
        logic [3:0]           strb;
        logic [31:0]          data;
        logic [31:0]          got;
        for (int i = 0; i < STROBE_TESTS; i++) begin
            word = `RAM_BITS'(random_bits(`RAM_BITS));
            model[word] = random_bits(32);
            bus_write(ram_address(word), model[word], 4'hF);
            strb = 4'(random_bits(4));
            data = random_bits(32);
            bus_write(ram_address(word), data, strb);
            for (int b = 0; b < 4; b++) begin
                if (strb[b])
                    model[word][b*8 +: 8] = data[b*8 +: 8];
            end
            bus_read(ram_address(word), got);
            check_value("rdata", got, model[word]);
        end
    endtask

    task automatic port_access;
        logic [6:0]  pins;
        logic [31:0] got;
        bus_write(region_base(`SEL_PORTS), 32'h2, 4'h1);
        check_value("{led,scl,sda}", 32'({led, scl, sda}), 32'h2);
        bus_write(region_base(`SEL_PORTS), 32'h5, 4'h1);
        check_value("{led,scl,sda}", 32'({led, scl, sda}), 32'h5);
        pins = 7'(random_bits(7));
        {con_button, psh_button, tra, trb, bak_button, scl_in, sda_in} = pins;
        bus_read(region_base(`SEL_PORTS), got);
        check_value("rdata", got, {25'b0, pins});
    endtask

    task automatic timer_interval(input int n);
        logic [31:0] got;
        int          elapsed;
        bus_write(region_base(`SEL_TIMER), 32'(n), 4'hF);
        elapsed = 0;
        while (!irq && elapsed < (n + 1) * `TIMER_PRESCALE) begin
            @(negedge mem_valid);
            elapsed++;
        end
        if (irq && elapsed <= (n - 1) * `TIMER_PRESCALE) begin
            errors++;
            $display("irq rose too early, after %0d cycles for a load of %0d", elapsed, n);
        end
        check_value("irq", 32'(irq), 32'd1);
        irq_clear = 1'b1;
        @(negedge mem_valid);
        irq_clear = 1'b0;
        check_value("irq", 32'(irq), 32'd0);
        // Read back while counting and stop with a zero load.
        bus_write(region_base(`SEL_TIMER), 32'(n), 4'hF);
        bus_read(region_base(`SEL_TIMER), got);
        if (got > 32'(n)) begin
            errors++;
            $display("timer read %0d is above its load of %0d", got, n);
        end
        bus_write(region_base(`SEL_TIMER), 32'd0, 4'hF);
        repeat ((n + 1) * `TIMER_PRESCALE) @(negedge mem_valid);
        check_value("irq", 32'(irq), 32'd0);
    endtask

    task automatic unmapped_access;
        logic [`RAM_BITS-1:0] word;
        logic [31:0]          got;
        addr = 32'h0000_0100;
        wstrb = 4'h0;
        read = 1'b1;
        @(negedge mem_valid);
        read = 1'b0;
        repeat (3) begin
            @(negedge mem_valid);
            check_value("ready", 32'(ready), 32'd0);
        end
        word = `RAM_BITS'(random_bits(`RAM_BITS));
        model[word] = random_bits(32);
        bus_write(ram_address(word), model[word], 4'hF);
        bus_read(ram_address(word), got);
        check_value("rdata", got, model[word]);
    endtask

    initial begin
        lfsr_state = 16'd82;
        errors = 0;
        checks = 0;
        cycles = 0;
        nreset = 1'b0;
        addr = '0;
        wdata = '0;
        wstrb = '0;
        read = 1'b0;
        write = 1'b0;
        irq_clear = 1'b0;
        {con_button, psh_button, tra, trb, bak_button, scl_in, sda_in} = 7'h0;
        repeat (5) @(posedge mem_valid);
        @(negedge mem_valid);
        nreset = 1'b1;
        check_reset_state();
        ram_words();
        byte_strobes();
        port_access();
        timer_interval(2 + int'(random_bits(3)));
        unmapped_access();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
design/soc_pkg.sv
design/bus_decoder.sv
design/ram_lane.sv
design/interval_timer.sv
design/io_ports.sv
design/read_mux.sv
design/soc_memory.sv
test/soc_memory_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the soc_memory testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module soc_memory_tb -o soc_memory_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/soc_memory_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
